//--- all.f
design/addr_pkg.sv
design/abl_unit.sv
design/abh_unit.sv
design/addr_combine.sv
design/addr_gen_top.sv
bench/tb_clock.sv
bench/addr_gen_assert.sv
bench/addr_gen_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the address generator testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    -f all.f \
    --top-module addr_gen_tb \
    -Mdir obj_dir \
    -o addr_gen_sim

# the simulator exits non-zero on a failure, the log decides
./obj_dir/addr_gen_sim > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "^=== PASS ===$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see $LOG"
    exit 1
fi

//--- bench/addr_gen_tb.sv
`timescale 1ns/1ps
`default_nettype none

module addr_gen_tb
    import addr_pkg::*;
;

    localparam addr_t       RESET_PC   = 16'hfffc;
    localparam int          N_CMDS     = 50;            // rough command count of all tests
    localparam int          MAX_CYCLES = N_CMDS * 40;   // timeout limit
    localparam logic [31:0] SEED       = 32'hadda_f28f;

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    logic      cmd_ready;
    base_sel_t base_sel;
    ofs_sel_t  ofs_sel;
    logic      ci;
    byte_t     db;
    byte_t     reg_lo;
    byte_t     reg_hi;
    logic      ld_ahl;
    logic      ld_ahh;
    logic      ld_pc;
    logic      inc_pc;
    logic      addr_valid;
    logic      addr_ready;
    addr_t     addr;
    logic      page_cross;

    // reference model state owned by the test process
    addr_t       m_ab;                          // address register
    addr_t       m_pc;                          // program counter
    byte_t       m_ahl;
    byte_t       m_ahh;
    logic [16:0] exp_q[$];                      // {page_cross, addr} in issue order
    int          n_sent;

    // sink side state owned by the checker process
    logic [16:0] exp_item;
    int          n_seen;
    int          stalls;                        // cycles seen with output stalled
    int          cycles;
    logic        stall_on;                      // random back-pressure enable
    int          span;                          // cycles left at current ready level

    tb_clock #(.PERIOD_NS(10)) u_clk (.clk(clk));

    addr_gen_top #(
        .RESET_PC (RESET_PC)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready),
        .base_sel   (base_sel),
        .ofs_sel    (ofs_sel),
        .ci         (ci),
        .db         (db),
        .reg_lo     (reg_lo),
        .reg_hi     (reg_hi),
        .ld_ahl     (ld_ahl),
        .ld_ahh     (ld_ahh),
        .ld_pc      (ld_pc),
        .inc_pc     (inc_pc),
        .addr_valid (addr_valid),
        .addr_ready (addr_ready),
        .addr       (addr),
        .page_cross (page_cross)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on first failure");
    endtask

    task automatic check_eq(input string name, input logic [15:0] exp, input logic [15:0] act);
        if (exp !== act) begin
            $display("error at %0t: %s expected %h got %h", $time, name, exp, act);
            fail_run("value mismatch");
        end
    endtask

    // predict the address, queue it, hand the command over, update the model
    task automatic issue(input base_sel_t bs, input ofs_sel_t os, input logic c, input byte_t d,
                         input addr_t rg, input logic lahl, input logic lahh,
                         input logic lpc, input logic ipc);
        addr_t      base;
        byte_t      ofs_l;
        byte_t      ofs_h;
        logic [8:0] lo;
        byte_t      hi;
        case (bs)
            BASE_PC:  base = m_pc;
            BASE_REG: base = rg;
            default:  base = m_ab;              // current address
        endcase
        ofs_l = (os == OFS_DB) ? d : ((os == OFS_AH) ? m_ahl : 8'h00);
        ofs_h = (os == OFS_AH) ? m_ahh : 8'h00; // db never reaches the high byte
        lo    = {1'b0, base[7:0]} + {1'b0, ofs_l} + {8'h00, c};
        hi    = base[15:8] + ofs_h + {7'h00, lo[8]};
        @(posedge clk);
        #1;
        cmd_valid = 1'b1;
        base_sel  = bs;
        ofs_sel   = os;
        ci        = c;
        db        = d;
        reg_lo    = rg[7:0];
        reg_hi    = rg[15:8];
        ld_ahl    = lahl;
        ld_ahh    = lahh;
        ld_pc     = lpc;
        inc_pc    = ipc;
        @(negedge clk);
        while (!cmd_ready) @(negedge clk);     // accepted on the next rising edge
        exp_q.push_back({lo[8], hi, lo[7:0]});
        n_sent = n_sent + 1;
        if (lpc) m_pc = m_ab + {15'h0000, ipc}; // old address before this command
        if (lahl) m_ahl = d;
        if (lahh) m_ahh = d;
        m_ab = {hi, lo[7:0]};
    endtask

    task automatic addr_cmd(input base_sel_t bs, input ofs_sel_t os, input logic c,
                            input byte_t d, input addr_t rg);
        issue(bs, os, c, d, rg, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    // drop valid after the last accept and wait for all addresses
    task automatic drain;
        @(posedge clk);
        #1;
        cmd_valid = 1'b0;
        ld_ahl    = 1'b0;
        ld_ahh    = 1'b0;
        ld_pc     = 1'b0;
        inc_pc    = 1'b0;
        while (n_seen != n_sent) @(negedge clk);
    endtask

    task automatic test_reset;
        @(negedge clk);
        check_eq("addr_valid", 16'h0000, {15'h0000, addr_valid});
        check_eq("cmd_ready", 16'h0001, {15'h0000, cmd_ready});
        addr_cmd(BASE_PC, OFS_NONE, 1'b0, 8'h00, 16'h0000);  // pc restore
        drain();
    endtask

    task automatic test_offsets;
        repeat (8) addr_cmd(BASE_REG, OFS_DB, 1'($urandom), 8'($urandom), 16'($urandom));
        addr_cmd(BASE_REG, OFS_DB, 1'b0, 8'h20, 16'h30f0);   // low byte crosses
        addr_cmd(BASE_REG, OFS_DB, 1'b1, 8'hff, 16'hff01);   // high byte wraps too
        addr_cmd(BASE_REG, OFS_NONE, 1'b1, 8'h55, 16'h12ff); // db ignored
        addr_cmd(BASE_REG, OFS_STAY, 1'b1, 8'h55, 16'h4410);
        drain();
    endtask

    task automatic test_hold;
        issue(BASE_REG, OFS_NONE, 1'b0, 8'hf0, 16'h0100, 1'b1, 1'b0, 1'b0, 1'b0);
        issue(BASE_REG, OFS_NONE, 1'b0, 8'h12, 16'h0101, 1'b0, 1'b1, 1'b0, 1'b0);
        // reload AHL while using it so the sum must see the old byte
        issue(BASE_REG, OFS_AH, 1'b1, 8'h33, 16'h0520, 1'b1, 1'b0, 1'b0, 1'b0);
        addr_cmd(BASE_REG, OFS_AH, 1'b0, 8'h00, 16'h0520);
        drain();
    endtask

    task automatic test_branch;
        addr_cmd(BASE_REG, OFS_NONE, 1'b0, 8'h00, 16'h20f0);
        addr_cmd(BASE_AB, OFS_DB, 1'b0, 8'h20, 16'h0000);    // branch across page
        addr_cmd(BASE_AB, OFS_STAY, 1'b1, 8'h00, 16'h0000);
        addr_cmd(BASE_REG, OFS_NONE, 1'b0, 8'h00, 16'h21fe);
        addr_cmd(BASE_AB, OFS_STAY, 1'b1, 8'h00, 16'h0000);  // 21ff
        addr_cmd(BASE_AB, OFS_STAY, 1'b1, 8'h00, 16'h0000);  // steps into next page
        repeat (2) addr_cmd(BASE_AB, OFS_DB, 1'b0, 8'($urandom), 16'h0000);
        drain();
    endtask

    task automatic test_pc;
        addr_cmd(BASE_REG, OFS_NONE, 1'b0, 8'h00, 16'h12ff);
        issue(BASE_REG, OFS_NONE, 1'b0, 8'h00, 16'h4000, 1'b0, 1'b0, 1'b1, 1'b1); // ff carry
        addr_cmd(BASE_PC, OFS_NONE, 1'b0, 8'h00, 16'h0000);
        issue(BASE_PC, OFS_STAY, 1'b1, 8'h00, 16'h0000, 1'b0, 1'b0, 1'b1, 1'b1);
        addr_cmd(BASE_PC, OFS_NONE, 1'b0, 8'h00, 16'h0000);
        issue(BASE_REG, OFS_NONE, 1'b0, 8'h00, 16'h0abc, 1'b0, 1'b0, 1'b1, 1'b0); // no inc
        addr_cmd(BASE_PC, OFS_NONE, 1'b0, 8'h00, 16'h0000);
        drain();
    endtask

    task automatic test_backpressure;
        stall_on = 1'b1;
        repeat (16) begin
            issue(base_sel_t'(2'($urandom_range(0, 2))), ofs_sel_t'(2'($urandom)),
                  1'($urandom), 8'($urandom), 16'($urandom),
                  1'($urandom), 1'($urandom), 1'($urandom), 1'($urandom));
        end
        drain();
        stall_on = 1'b0;
        if (stalls == 0) fail_run("back-pressure test never stalled the output");
    endtask

    // sink side ready with random spans when back-pressure is on
    always @(posedge clk) begin
        #1;
        if (!stall_on) begin
            addr_ready = 1'b1;
        end else begin
            if (span == 0) begin
                addr_ready = 1'($urandom);
                span       = $urandom_range(1, 4);
            end
            span = span - 1;
        end
    end

    // output checker sampling mid cycle
    always @(negedge clk) begin
        if (rst_n && addr_valid) begin
            if (addr_ready) begin
                if (n_seen >= n_sent) fail_run("address arrived with no command outstanding");
                exp_item = exp_q[n_seen];       // in order and each once
                check_eq("addr", exp_item[15:0], addr);
                check_eq("page_cross", {15'h0000, exp_item[16]}, {15'h0000, page_cross});
                n_seen = n_seen + 1;
            end else begin
                stalls = stalls + 1;
                check_eq("cmd_ready", 16'h0000, {15'h0000, cmd_ready});
            end
        end
    end

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) fail_run("timeout: tests did not finish in time");
    end

    initial begin
        void'($urandom(SEED));
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        base_sel   = BASE_PC;
        ofs_sel    = OFS_NONE;
        ci         = 1'b0;
        db         = 8'h00;
        reg_lo     = 8'h00;
        reg_hi     = 8'h00;
        ld_ahl     = 1'b0;
        ld_ahh     = 1'b0;
        ld_pc      = 1'b0;
        inc_pc     = 1'b0;
        addr_ready = 1'b1;
        stall_on   = 1'b0;
        span       = 0;
        n_sent     = 0;
        n_seen     = 0;
        stalls     = 0;
        cycles     = 0;
        m_ab       = 16'h0000;                  // reset values of the model
        m_pc       = RESET_PC;
        m_ahl      = 8'h00;
        m_ahh      = 8'h00;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_offsets();
        test_hold();
        test_branch();
        test_pc();
        test_backpressure();
        @(negedge clk);                         // last address consumed on the edge before
        if (!addr_valid) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            fail_run("address output still valid after the last address was consumed");
        end
    end

endmodule

`default_nettype wire

//--- bench/addr_gen_assert.sv
`timescale 1ns/1ps
`default_nettype none

module addr_gen_assert
    import addr_pkg::*;
(
    input wire logic  clk,
    input wire logic  rst_n,
    input wire logic  cmd_ready,
    input wire logic  addr_valid,
    input wire logic  addr_ready,
    input wire addr_t addr,
    input wire logic  page_cross
);

    // stalled output must not move
    property stall_hold_p;
        @(posedge clk) disable iff (!rst_n)
            (addr_valid && !addr_ready) |=>
                (addr_valid && $stable(addr) && $stable(page_cross));
    endproperty

    // single slot ready rule
    property ready_rule_p;
        @(posedge clk) disable iff (!rst_n)
            cmd_ready == (!addr_valid || addr_ready);
    endproperty

    // nothing can be valid right out of reset
    property reset_empty_p;
        @(posedge clk) $rose(rst_n) |-> !addr_valid;
    endproperty

    stall_hold_a:  assert property (stall_hold_p)  else $error("output moved while stalled");
    ready_rule_a:  assert property (ready_rule_p)  else $error("cmd_ready rule broken");
    reset_empty_a: assert property (reset_empty_p) else $error("addr_valid set after reset");

endmodule

bind addr_gen_top addr_gen_assert u_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_ready  (cmd_ready),
    .addr_valid (addr_valid),
    .addr_ready (addr_ready),
    .addr       (addr),
    .page_cross (page_cross)
);

`default_nettype wire

//--- bench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD_NS = 10                // full clock period
) (
    output logic clk
);

    initial clk = 1'b0;                         // known level at time zero

    always #(PERIOD_NS / 2) clk = ~clk;         // half period toggle

endmodule

`default_nettype wire

//--- design/addr_gen_top.sv
`timescale 1ns/1ps
`default_nettype none

module addr_gen_top
    import addr_pkg::*;
#(
    parameter addr_t RESET_PC = 16'h0000        // pc after reset
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    // command channel
    input  wire logic      cmd_valid,
    output logic           cmd_ready,
    input  wire base_sel_t base_sel,
    input  wire ofs_sel_t  ofs_sel,
    input  wire logic      ci,
    input  wire byte_t     db,
    input  wire byte_t     reg_lo,
    input  wire byte_t     reg_hi,
    input  wire logic      ld_ahl,
    input  wire logic      ld_ahh,
    input  wire logic      ld_pc,
    input  wire logic      inc_pc,
    // address channel
    output logic           addr_valid,
    input  wire logic      addr_ready,
    output addr_t          addr,
    output logic           page_cross
);

    logic  take;                                // accept strobe to all units
    byte_t sum_lo;
    logic  co_lo;
    logic  pcl_co;
    byte_t hi_nc;
    byte_t hi_c;
    byte_t ab_lo;                               // address register feedback
    byte_t ab_hi;

    // single slot is free when empty or draining this cycle
    assign cmd_ready = !addr_valid || addr_ready;
    assign take      = cmd_valid && cmd_ready;

    abl_unit #(
        .RESET_PCL (RESET_PC[7:0])
    ) u_abl (
        .clk      (clk),
        .rst_n    (rst_n),
        .take     (take),
        .base_sel (base_sel),
        .ofs_sel  (ofs_sel),
        .ci       (ci),
        .db       (db),
        .reg_lo   (reg_lo),
        .ab_lo    (ab_lo),
        .ld_ahl   (ld_ahl),
        .ld_pc    (ld_pc),
        .inc_pc   (inc_pc),
        .sum_lo   (sum_lo),
        .co_lo    (co_lo),
        .pcl_co   (pcl_co)
    );

    abh_unit #(
        .RESET_PCH (RESET_PC[15:8])
    ) u_abh (
        .clk      (clk),
        .rst_n    (rst_n),
        .take     (take),
        .base_sel (base_sel),
        .ofs_sel  (ofs_sel),
        .db       (db),
        .reg_hi   (reg_hi),
        .ab_hi    (ab_hi),
        .ld_ahh   (ld_ahh),
        .ld_pc    (ld_pc),
        .pcl_co   (pcl_co),
        .hi_nc    (hi_nc),
        .hi_c     (hi_c)
    );

    addr_combine u_comb (
        .clk        (clk),
        .rst_n      (rst_n),
        .take       (take),
        .sum_lo     (sum_lo),
        .co_lo      (co_lo),
        .hi_nc      (hi_nc),
        .hi_c       (hi_c),
        .addr_ready (addr_ready),
        .ab_lo      (ab_lo),
        .ab_hi      (ab_hi),
        .addr       (addr),
        .addr_valid (addr_valid),
        .page_cross (page_cross)
    );

endmodule

`default_nettype wire

//--- design/addr_combine.sv
`timescale 1ns/1ps
`default_nettype none

module addr_combine
    import addr_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  rst_n,
    input  wire logic  take,                    // load a new address
    input  wire byte_t sum_lo,                  // low byte from abl_unit
    input  wire logic  co_lo,                   // low byte carry
    input  wire byte_t hi_nc,                   // high candidate without carry
    input  wire byte_t hi_c,                    // high candidate with carry
    input  wire logic  addr_ready,              // sink accepts addr
    output byte_t      ab_lo,                   // feedback for BASE_AB and pc
    output byte_t      ab_hi,
    output addr_t      addr,                    // registered address bus
    output logic       addr_valid,
    output logic       page_cross               // low byte carried into high
);

    byte_t hi_sel;                              // chosen high byte
    addr_t ab_q;                                // address register
    logic  pc_q;                                // page cross flag
    logic  vld_q;                               // output holds a live address

    // late select on the low carry
    assign hi_sel = co_lo ? hi_c : hi_nc;

    // address register only moves on an accepted command
    // stall holds it because take is low then
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ab_q <= '0;
            pc_q <= 1'b0;
        end else if (take) begin
            ab_q <= {hi_sel, sum_lo};
            pc_q <= co_lo;
        end
    end

    // valid flag of the output stage
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= 1'b0;
        end else if (take) begin
            vld_q <= 1'b1;                      // new address whether consumed or not
        end else if (addr_ready) begin
            vld_q <= 1'b0;                      // consumed with nothing behind it
        end
    end

    // outputs straight from flops
    assign addr       = ab_q;
    assign page_cross = pc_q;
    assign addr_valid = vld_q;

    // byte split back to the two units
    assign ab_lo = ab_q[7:0];
    assign ab_hi = ab_q[15:8];

endmodule

`default_nettype wire

//--- design/abh_unit.sv
`timescale 1ns/1ps
`default_nettype none

module abh_unit
    import addr_pkg::*;
#(
    parameter byte_t RESET_PCH = 8'h00          // pc high byte after reset
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      take,                // command accepted this cycle
    input  wire base_sel_t base_sel,
    input  wire ofs_sel_t  ofs_sel,
    input  wire byte_t     db,                  // data bus byte
    input  wire byte_t     reg_hi,              // register high for stack or zero page
    input  wire byte_t     ab_hi,               // registered address high
    input  wire logic      ld_ahh,
    input  wire logic      ld_pc,
    input  wire logic      pcl_co,              // carry from pc low increment
    output byte_t          hi_nc,               // high sum without carry in
    output byte_t          hi_c                 // high sum with carry in
);

    byte_t pch;                                 // program counter high
    byte_t ahh;                                 // address hold high
    byte_t base_hi;                             // selected base
    byte_t ofs_hi;                              // AHH or zero

    // base select mirrors the low half
    always_comb begin
        case (base_sel)
            BASE_PC:  base_hi = pch;
            BASE_REG: base_hi = reg_hi;
            default:  base_hi = ab_hi;          // BASE_AB and spare code
        endcase
    end

    // only absolute mode has a high offset
    // db is a low byte offset so the high half sees zero
    always_comb begin
        if (ofs_sel == OFS_AH) begin
            ofs_hi = ahh;                       // value before this command
        end else begin
            ofs_hi = '0;
        end
    end

    // both carry select candidates in parallel with the low adder
    assign hi_nc = base_hi + ofs_hi;
    assign hi_c  = base_hi + ofs_hi + 8'h01;    // wraps mod 256

    // AHH captures db as the second operand byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ahh <= '0;
        end else if (take && ld_ahh) begin
            ahh <= db;
        end
    end

    // PCH follows old address high plus low increment carry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pch <= RESET_PCH;
        end else if (take && ld_pc) begin
            pch <= ab_hi + {7'h00, pcl_co};
        end
    end

endmodule

`default_nettype wire

//--- design/abl_unit.sv
`timescale 1ns/1ps
`default_nettype none

module abl_unit
    import addr_pkg::*;
#(
    parameter byte_t RESET_PCL = 8'h00          // pc low byte after reset
) (
    input  wire logic      clk,
    input  wire logic      rst_n,
    input  wire logic      take,                // command accepted this cycle
    input  wire base_sel_t base_sel,
    input  wire ofs_sel_t  ofs_sel,
    input  wire logic      ci,                  // carry into low byte
    input  wire byte_t     db,                  // data bus byte
    input  wire byte_t     reg_lo,              // register pair low
    input  wire byte_t     ab_lo,               // registered address low
    input  wire logic      ld_ahl,
    input  wire logic      ld_pc,
    input  wire logic      inc_pc,
    output byte_t          sum_lo,              // unregistered low address
    output logic           co_lo,               // carry into high byte
    output logic           pcl_co               // carry out of pc low increment
);

    byte_t      pcl;                            // program counter low
    byte_t      ahl;                            // address hold low
    byte_t      base_lo;                        // selected base
    byte_t      ofs_lo;                         // selected offset
    logic [8:0] pcl_next;                       // pc increment incl carry

    // base select
    always_comb begin
        case (base_sel)
            BASE_PC:  base_lo = pcl;
            BASE_REG: base_lo = reg_lo;
            default:  base_lo = ab_lo;          // BASE_AB and spare code
        endcase
    end

    // offset select
    always_comb begin
        case (ofs_sel)
            OFS_DB:  ofs_lo = db;
            OFS_AH:  ofs_lo = ahl;              // old hold value as it loads on the same edge
            default: ofs_lo = '0;               // none / stay
        endcase
    end

    // 9 bit add with the page carry on top
    assign {co_lo, sum_lo} = {1'b0, base_lo} + {1'b0, ofs_lo} + {8'h00, ci};

    // pc low built from the address held before this command
    assign pcl_next = {1'b0, ab_lo} + {8'h00, inc_pc};
    assign pcl_co   = pcl_next[8];              // feeds pch

    // AHL captures db for absolute modes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ahl <= '0;
        end else if (take && ld_ahl) begin
            ahl <= db;
        end
    end

    // PCL load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcl <= RESET_PCL;
        end else if (take && ld_pc) begin
            pcl <= pcl_next[7:0];               // carry goes to pch instead
        end
    end

endmodule

`default_nettype wire

//--- design/addr_pkg.sv
`default_nettype none

package addr_pkg;

    // one bus byte for address or data
    typedef logic [7:0] byte_t;

    // full cpu address bus
    typedef logic [15:0] addr_t;

    // base select for both address halves
    typedef enum logic [1:0] {
        BASE_PC  = 2'b00,   // program counter for pc restore
        BASE_REG = 2'b01,   // register pair for stack / zero page / vector
        BASE_AB  = 2'b10    // current address for branch or stay
    } base_sel_t;           // 2'b11 unused and decoded as BASE_AB

    // offset select, added on top of the base
    typedef enum logic [1:0] {
        OFS_NONE = 2'b00,   // base + 0 + ci
        OFS_STAY = 2'b01,   // base + 0 + ci like none
        OFS_DB   = 2'b10,   // low byte gets data bus added
        OFS_AH   = 2'b11    // both bytes get the hold registers added
    } ofs_sel_t;

    // table of useful combinations
    //   PC  + NONE   pc restore
    //   REG + STAY   stack access or vector pull
    //   AB  + DB     taken branch
    //   AB  + STAY   stay or step to next address
    //   REG + DB     zero page + index
    //   REG + AH     absolute + index

endpackage

`default_nettype wire
